// ==== src/fog_macros.svh ====
`ifndef FOG_MACROS_SVH
`define FOG_MACROS_SVH

// Converter widths
`define FOG_ADC_W 14 // Raw ADC word, offset binary
`define FOG_DAC_W 16 // DAC code

// Error, step, ramp and register word
`define FOG_WORD_W 32

// N32FC2 low-pass
`define FOG_FIR_TAPS 32
`define FOG_FIR_SHIFT 15 // Coefficients sum just under 2^15

// Shortest half period, keeps one error in flight through the FIR
`define FOG_MIN_HALF 40

`endif

// ==== src/fog_pkg.sv ====
`include "fog_macros.svh"

package fog_pkg;

	// ADC sample as delivered by the converter
	typedef logic [`FOG_ADC_W-1:0] adc_sample_t;

	// DAC code, wraps modulo 2^16
	typedef logic [`FOG_DAC_W-1:0] dac_code_t;

	// Signed loop quantities
	typedef logic signed [`FOG_WORD_W-1:0] fog_word_t; // Error, step, ramp

	// Cycle counts and timing settings
	typedef logic [`FOG_WORD_W-1:0] cnt_t;

	typedef logic [2:0] avg_sel_t; // log2 of samples per half
	typedef logic [4:0] gain_sel_t; // Feedback gain shift

	// FIR sequencer
	typedef enum logic [1:0] {
		FIR_IDLE, // Waiting for a new error
		FIR_MAC, // One tap per cycle
		FIR_DONE // Normalize and strobe
	} fir_state_t;

endpackage

// ==== src/fog_mod_gen.sv ====
`timescale 1ns/100ps
`include "fog_macros.svh"

module fog_mod_gen (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::cnt_t i_freq_cnt, // Half period in cycles
	output logic o_mod_phase, // 0 high half, 1 low half
	output logic o_half_start // Last cycle of a half
);
	import fog_pkg::*;

	cnt_t half_len; // Clamped half period
	cnt_t remain; // Cycles left in this half, this one included
	cnt_t cnt_q; // Zero means reload

	// Too short a half would overrun the FIR
	assign half_len = (i_freq_cnt < `FOG_MIN_HALF) ? cnt_t'(`FOG_MIN_HALF) : i_freq_cnt;

	// Reload folded into the count, so the first half also lasts half_len
	assign remain = (cnt_q == '0) ? half_len : cnt_q;

	assign o_half_start = (remain == cnt_t'(1)); // One cycle per half

	// Down counter
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= remain - cnt_t'(1); // Reaches zero after the pulse
		end
	end

	// Bias phase, flips on the edge that closes a half
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			o_mod_phase <= 1'b0; // Start in the high half
		end else if (o_half_start) begin
			o_mod_phase <= ~o_mod_phase;
		end
	end

endmodule

// ==== src/fog_err_demod.sv ====
`timescale 1ns/100ps
`include "fog_macros.svh"

module fog_err_demod (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::adc_sample_t i_adc, // Offset binary
	input logic i_mod_phase, // 0 high half, 1 low half
	input logic i_half_start, // Last cycle of the half
	input fog_pkg::cnt_t i_wait_cnt, // Settling cycles before the window
	input fog_pkg::avg_sel_t i_avg_sel, // log2 window length
	input logic i_polarity, // Negate the error
	input fog_pkg::fog_word_t i_err_offset,
	output fog_pkg::fog_word_t o_err,
	output logic o_err_valid
);
	import fog_pkg::*;

	logic signed [`FOG_ADC_W-1:0] adc_s; // Two's complement sample
	fog_word_t sample_w; // Sign extended
	cnt_t idx_q; // Cycle within the half
	cnt_t win_end; // First cycle past the window
	logic in_win;
	fog_word_t acc_q; // Running sum of this half
	fog_word_t sum_now; // Sum including the current sample
	fog_word_t high_sum_q; // Latched at the end of the high half
	fog_word_t diff;
	fog_word_t scaled;
	fog_word_t err_next;

	// Offset binary to signed, MSB flip
	assign adc_s = {~i_adc[`FOG_ADC_W-1], i_adc[`FOG_ADC_W-2:0]};
	assign sample_w = adc_s;

	// Averaging window after the settling time
	assign win_end = i_wait_cnt + (cnt_t'(1) << i_avg_sel);
	assign in_win = (idx_q >= i_wait_cnt) && (idx_q < win_end);

	// Window may run up to the last cycle of the half
	assign sum_now = in_win ? acc_q + sample_w : acc_q;

	// High minus low, back to one sample's scale
	assign diff = high_sum_q - sum_now;
	assign scaled = diff >>> i_avg_sel;
	assign err_next = (i_polarity ? -scaled : scaled) + i_err_offset;

	// Cycle index, restarts with each half
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			idx_q <= '0;
		end else if (i_half_start) begin
			idx_q <= '0;
		end else begin
			idx_q <= idx_q + cnt_t'(1);
		end
	end

	// Accumulate, latch per half
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			acc_q <= '0;
			high_sum_q <= '0;
			o_err <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= 1'b0; // Strobe
			if (i_half_start) begin
				acc_q <= '0; // Fresh sum for the next half
				if (!i_mod_phase) begin
					high_sum_q <= sum_now; // High half done
				end else begin
					o_err <= err_next; // Low half done, one error per period
					o_err_valid <= 1'b1;
				end
			end else begin
				acc_q <= sum_now;
			end
		end
	end

endmodule

// ==== src/fog_fir.sv ====
`timescale 1ns/100ps
`include "fog_macros.svh"

module fog_fir (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::fog_word_t i_err,
	input logic i_err_valid,
	output fog_pkg::fog_word_t o_err_fir,
	output logic o_fir_valid // 34 cycles after i_err_valid
);
	import fog_pkg::*;

	localparam int ACC_W = `FOG_WORD_W + 16; // Word times 16-bit coefficient
	localparam int TAP_W = $clog2(`FOG_FIR_TAPS);

	// N32FC2, symmetric, sum 32762
	localparam logic signed [15:0] COEF [0:`FOG_FIR_TAPS-1] = '{
		16'sd82, 16'sd102, 16'sd148, 16'sd223, 16'sd330, 16'sd469, 16'sd638, 16'sd832,
		16'sd1042, 16'sd1261, 16'sd1476, 16'sd1678, 16'sd1855, 16'sd1998, 16'sd2098,
		16'sd2149, 16'sd2149, 16'sd2098, 16'sd1998, 16'sd1855, 16'sd1678, 16'sd1476,
		16'sd1261, 16'sd1042, 16'sd832, 16'sd638, 16'sd469, 16'sd330, 16'sd223,
		16'sd148, 16'sd102, 16'sd82
	};

	fir_state_t state_q;
	logic [TAP_W-1:0] tap_q; // Tap being multiplied
	fog_word_t dl_q [0:`FOG_FIR_TAPS-1]; // Index 0 newest
	logic signed [ACC_W-1:0] prod; // Single multiplier
	logic signed [ACC_W-1:0] acc_q;

	assign prod = COEF[tap_q] * dl_q[tap_q];

	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			state_q <= FIR_IDLE;
			tap_q <= '0;
			acc_q <= '0;
			o_err_fir <= '0;
			o_fir_valid <= 1'b0;
			for (int i = 0; i < `FOG_FIR_TAPS; i++) begin
				dl_q[i] <= '0; // History starts empty
			end
		end else begin
			o_fir_valid <= 1'b0;
			case (state_q)
				FIR_IDLE: begin
					if (i_err_valid) begin
						for (int i = `FOG_FIR_TAPS-1; i > 0; i--) begin
							dl_q[i] <= dl_q[i-1]; // Age the history
						end
						dl_q[0] <= i_err;
						tap_q <= '0;
						acc_q <= '0;
						state_q <= FIR_MAC;
					end
				end
				FIR_MAC: begin
					acc_q <= acc_q + prod; // 32 cycles
					tap_q <= tap_q + 1'b1;
					if (tap_q == TAP_W'(`FOG_FIR_TAPS-1)) begin
						state_q <= FIR_DONE;
					end
				end
				FIR_DONE: begin
					o_err_fir <= fog_word_t'(acc_q >>> `FOG_FIR_SHIFT); // Unity gain
					o_fir_valid <= 1'b1;
					state_q <= FIR_IDLE;
				end
				default: state_q <= FIR_IDLE;
			endcase
		end
	end

endmodule

// ==== src/fog_step_ctrl.sv ====
`timescale 1ns/100ps

module fog_step_ctrl (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::fog_word_t i_err_fir, // Filtered rate error
	input logic i_fir_valid,
	input logic i_fb_on, // Closed loop
	input fog_pkg::gain_sel_t i_gain_sel, // Gain as a right shift
	input fog_pkg::fog_word_t i_const_step, // Open-loop step
	output fog_pkg::fog_word_t o_step // Held between strobes
);
	import fog_pkg::*;

	fog_word_t err_scaled; // Loop gain applied
	fog_word_t step_next;

	// Arithmetic shift keeps the sign
	assign err_scaled = i_err_fir >>> i_gain_sel;

	// Integrate when closed, else constant
	assign step_next = i_fb_on ? o_step + err_scaled : i_const_step;

	// Update one cycle after the FIR strobe
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			o_step <= '0;
		end else if (i_fir_valid) begin
			o_step <= step_next;
		end
	end

endmodule

// ==== src/fog_phase_ramp.sv ====
`timescale 1ns/100ps

module fog_phase_ramp (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::fog_word_t i_step, // Ramp increment per half
	input logic i_half_start,
	input logic i_mod_phase, // 0 high half, 1 low half
	input fog_pkg::fog_word_t i_amp_h, // Bias level, high half
	input fog_pkg::fog_word_t i_amp_l, // Bias level, low half
	output fog_pkg::dac_code_t o_dac
);
	import fog_pkg::*;

	fog_word_t ramp_q; // Serrodyne phase, wraps freely
	dac_code_t amp_code; // Bias of the current half
	dac_code_t dac_next;

	// Only the low bits reach the DAC
	assign amp_code = i_mod_phase ? dac_code_t'(i_amp_l) : dac_code_t'(i_amp_h);
	assign dac_next = dac_code_t'(ramp_q) + amp_code; // Modulo 2^16

	// One step per half, same edge as the phase flip
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			ramp_q <= '0;
		end else if (i_half_start) begin
			ramp_q <= ramp_q + i_step;
		end
	end

	// Registered DAC code, one cycle behind ramp and phase
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			o_dac <= '0;
		end else begin
			o_dac <= dac_next;
		end
	end

endmodule

// ==== src/fog_channel_top.sv ====
`timescale 1ns/100ps

module fog_channel_top (
	input logic CLOCK_DAC,
	input logic locked_0, // Active low
	input fog_pkg::adc_sample_t i_adc,
	input fog_pkg::cnt_t i_freq_cnt, // Half period
	input fog_pkg::fog_word_t i_amp_h,
	input fog_pkg::fog_word_t i_amp_l,
	input logic i_polarity,
	input fog_pkg::cnt_t i_wait_cnt,
	input fog_pkg::avg_sel_t i_avg_sel,
	input fog_pkg::fog_word_t i_err_offset,
	input fog_pkg::gain_sel_t i_gain_sel_step,
	input fog_pkg::fog_word_t i_const_step,
	input logic i_fb_on,
	output fog_pkg::dac_code_t o_dac,
	output fog_pkg::fog_word_t o_err, // Demodulated error
	output logic o_err_valid,
	output fog_pkg::fog_word_t o_err_fir, // Low-passed error
	output logic o_fir_valid,
	output fog_pkg::fog_word_t o_step // Feedback step
);

	logic mod_phase; // Bias half
	logic half_start; // Loop timing base

	// Input side
	fog_mod_gen u_mod_gen (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_freq_cnt (i_freq_cnt),
		.o_mod_phase (mod_phase),
		.o_half_start (half_start)
	);

	fog_err_demod u_err_demod (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_adc (i_adc),
		.i_mod_phase (mod_phase),
		.i_half_start (half_start),
		.i_wait_cnt (i_wait_cnt),
		.i_avg_sel (i_avg_sel),
		.i_polarity (i_polarity),
		.i_err_offset (i_err_offset),
		.o_err (o_err),
		.o_err_valid (o_err_valid)
	);

	// Processing
	fog_fir u_fir (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_err (o_err),
		.i_err_valid (o_err_valid),
		.o_err_fir (o_err_fir),
		.o_fir_valid (o_fir_valid)
	);

	fog_step_ctrl u_step_ctrl (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_err_fir (o_err_fir),
		.i_fir_valid (o_fir_valid),
		.i_fb_on (i_fb_on),
		.i_gain_sel (i_gain_sel_step),
		.i_const_step (i_const_step),
		.o_step (o_step)
	);

	// Output side, to the DAC
	fog_phase_ramp u_phase_ramp (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_step (o_step),
		.i_half_start (half_start),
		.i_mod_phase (mod_phase),
		.i_amp_h (i_amp_h),
		.i_amp_l (i_amp_l),
		.o_dac (o_dac)
	);

endmodule

// ==== tests/fog_channel_props.sv ====
`timescale 1ns/100ps

module fog_channel_props (
	input logic CLOCK_DAC,
	input logic locked_0,
	input fog_pkg::cnt_t i_freq_cnt, // Half period
	input logic i_err_valid,
	input logic i_fir_valid
);
	import fog_pkg::*;

	cnt_t run_cnt; // Cycles since reset release, saturates
	logic [5:0] since_err; // Cycles since the error strobe, 0 when idle

	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			run_cnt <= '0;
		end else if (run_cnt != '1) begin
			run_cnt <= run_cnt + cnt_t'(1);
		end
	end

	// FIR latency tracker
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			since_err <= '0;
		end else if (i_err_valid) begin
			since_err <= 6'd1;
		end else if (since_err == 6'd34) begin
			since_err <= '0; // Filtered result due now
		end else if (since_err != '0) begin
			since_err <= since_err + 6'd1;
		end
	end

	a_err_single: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		i_err_valid |=> !i_err_valid)
		else $error("o_err_valid high for two cycles running");

	// Strobe exactly when the tracker reaches the latency
	a_fir_latency: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		i_fir_valid == (since_err == 6'd34))
		else $error("o_fir_valid not 34 cycles after o_err_valid");

	// Nothing to report before one full modulation period
	a_quiet_start: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		(run_cnt < (i_freq_cnt << 1)) |-> (!i_err_valid && !i_fir_valid))
		else $error("strobe before the first modulation period ended");

endmodule

bind fog_channel_top fog_channel_props u_props (
	.CLOCK_DAC (CLOCK_DAC),
	.locked_0 (locked_0),
	.i_freq_cnt (i_freq_cnt),
	.i_err_valid (o_err_valid),
	.i_fir_valid (o_fir_valid)
);

// ==== tests/tb_fog_channel.sv ====
`timescale 1ns/100ps

module tb_fog_channel;
	import fog_pkg::*;

	localparam int HALF = 64; // Half period in cycles
	localparam int WAIT = 8; // Settling cycles per half
	localparam int LIMIT = 20000; // Tests need about 7300 cycles

	logic CLOCK_DAC;
	logic locked_0;
	adc_sample_t adc;
	cnt_t freq_cnt;
	fog_word_t amp_h;
	fog_word_t amp_l;
	logic polarity;
	cnt_t wait_cnt;
	avg_sel_t avg_sel;
	fog_word_t err_offset;
	gain_sel_t gain_sel_step;
	fog_word_t const_step;
	logic fb_on;
	dac_code_t dac;
	fog_word_t err;
	logic err_valid;
	fog_word_t err_fir;
	logic fir_valid;
	fog_word_t step;
	logic [31:0] lfsr_q; // Galois LFSR state
	int cycle_cnt; // Watchdog

	fog_channel_top i_dut (
		.CLOCK_DAC (CLOCK_DAC),
		.locked_0 (locked_0),
		.i_adc (adc),
		.i_freq_cnt (freq_cnt),
		.i_amp_h (amp_h),
		.i_amp_l (amp_l),
		.i_polarity (polarity),
		.i_wait_cnt (wait_cnt),
		.i_avg_sel (avg_sel),
		.i_err_offset (err_offset),
		.i_gain_sel_step (gain_sel_step),
		.i_const_step (const_step),
		.i_fb_on (fb_on),
		.o_dac (dac),
		.o_err (err),
		.o_err_valid (err_valid),
		.o_err_fir (err_fir),
		.o_fir_valid (fir_valid),
		.o_step (step)
	);

	always #5 CLOCK_DAC = ~CLOCK_DAC; // 100 MHz

	always @(posedge CLOCK_DAC) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("Timeout after %0d cycles, a strobe never arrived", cycle_cnt);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// Taps x^32+x^22+x^2+x+1 stepped once per bit taken
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int b = 0; b < n; b++) begin
			bits = {bits[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
		end
		return bits;
	endfunction

	// Offset binary to signed by MSB inversion
	function automatic int adc_value(input adc_sample_t a);
		logic signed [13:0] s;
		s = {~a[13], a[12:0]};
		return int'(s);
	endfunction

	task automatic tick();
		@(posedge CLOCK_DAC);
		#1; // Drive and sample clear of the edge
	endtask

	task automatic check_val(input string test, input string what, input longint exp,
			input longint act);
		assert (act == exp) else begin
			$display("ERR %s %s: expected %0d, actual %0d", test, what, exp, act);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_reset_state(input string test);
		check_val(test, "o_dac", 0, dac);
		check_val(test, "o_err", 0, err);
		check_val(test, "o_err_fir", 0, err_fir);
		check_val(test, "o_step", 0, step);
		check_val(test, "o_err_valid", 0, err_valid);
		check_val(test, "o_fir_valid", 0, fir_valid);
	endtask

	// Reset plus baseline configuration
	task automatic enter_reset();
		locked_0 = 1'b0;
		adc = 14'h2000; // Mid scale
		freq_cnt = cnt_t'(HALF);
		wait_cnt = cnt_t'(WAIT);
		amp_h = '0;
		amp_l = '0;
		polarity = 1'b0;
		avg_sel = '0;
		err_offset = '0;
		gain_sel_step = '0;
		const_step = '0;
		fb_on = 1'b0;
	endtask

	task automatic release_reset();
		repeat (2) tick();
		locked_0 = 1'b1; // Half boundaries now every HALF edges
	endtask

	task automatic wait_err_strobe(input string test);
		int n;
		n = 0;
		tick();
		while (!err_valid && n < 3 * HALF) begin
			tick();
			n++;
		end
		assert (err_valid) else begin
			$display("%s: no o_err_valid within %0d cycles", test, 3 * HALF);
			$display("Test failed");
			$fatal(1, "missing error strobe");
		end
	endtask

	task automatic wait_fir_strobe(input string test);
		int n;
		n = 0;
		tick();
		while (!fir_valid && n < 3 * HALF) begin
			tick();
			n++;
		end
		assert (fir_valid) else begin
			$display("%s: no o_fir_valid within %0d cycles", test, 3 * HALF);
			$display("Test failed");
			$fatal(1, "missing filter strobe");
		end
	endtask

	// One modulation period ending on the error strobe
	// The other half's level fills the cycles outside each window
	task automatic run_period(input string test, input int n, input adc_sample_t h,
			input adc_sample_t l);
		adc = l; // Still settling from the low half
		repeat (WAIT) tick();
		adc = h;
		repeat (n) tick();
		adc = l; // Past the window
		repeat (HALF - WAIT - n) tick();
		adc = h; // Settling from the high half
		repeat (WAIT) tick();
		adc = l;
		repeat (n) tick();
		adc = h;
		wait_err_strobe(test);
	endtask

	task automatic reset_values();
		enter_reset();
		tick(); // First edge under reset
		check_reset_state("reset");
		tick();
		locked_0 = 1'b1;
		check_reset_state("after_reset");
		repeat (8) begin
			tick();
			check_reset_state("after_reset");
		end
	endtask

	task automatic constant_adc();
		fog_word_t exp_fir;
		enter_reset();
		adc = adc_sample_t'(lfsr_take(14));
		err_offset = -32'sd4321;
		avg_sel = 3'd3;
		release_reset();
		for (int k = 0; k < 32; k++) begin
			wait_err_strobe("const_adc");
			check_val("const_adc", "o_err", err_offset, err);
		end
		exp_fir = fog_word_t'((longint'(err_offset) * 32762) >>> 15); // Full delay line
		wait_fir_strobe("const_adc");
		check_val("const_adc", "o_err_fir", exp_fir, err_fir);
	endtask

	task automatic demod_levels();
		adc_sample_t h;
		adc_sample_t l;
		int n;
		int expected;
		for (int a = 0; a <= 4; a += 2) begin
			n = 1 << a; // Samples per window
			for (int p = 0; p < 2; p++) begin
				enter_reset();
				avg_sel = avg_sel_t'(a);
				polarity = p[0];
				err_offset = 32'sd300;
				release_reset();
				for (int r = 0; r < 2; r++) begin
					h = adc_sample_t'(lfsr_take(14));
					l = adc_sample_t'(lfsr_take(14));
					run_period("demod", n, h, l);
					expected = (n * adc_value(h) - n * adc_value(l)) >>> a;
					if (p != 0) begin
						expected = -expected;
					end
					expected = expected + 300;
					check_val("demod", "o_err", expected, err);
				end
			end
		end
	endtask

	task automatic open_loop_ramp();
		dac_code_t d0;
		dac_code_t d1;
		dac_code_t d2;
		enter_reset();
		adc = adc_sample_t'(lfsr_take(14));
		const_step = fog_word_t'(lfsr_take(20));
		amp_h = fog_word_t'(lfsr_take(16));
		amp_l = fog_word_t'(lfsr_take(16));
		release_reset();
		wait_err_strobe("open_loop");
		wait_fir_strobe("open_loop"); // Step loads on the first filter strobe
		tick();
		check_val("open_loop", "o_step", const_step, step);
		for (int k = 0; k < 3; k++) begin
			wait_err_strobe("open_loop"); // High half starts here
			repeat (HALF / 2) tick();
			d0 = dac;
			repeat (HALF) tick();
			d1 = dac; // Mid low half
			repeat (HALF) tick();
			d2 = dac;
			check_val("open_loop", "high to high", dac_code_t'(2 * const_step),
				dac_code_t'(d2 - d0));
			check_val("open_loop", "high to low", dac_code_t'(const_step + amp_l - amp_h),
				dac_code_t'(d1 - d0));
			check_val("open_loop", "o_step", const_step, step);
		end
	endtask

	task automatic closed_loop_step();
		fog_word_t exp_step;
		fog_word_t filt;
		enter_reset();
		adc = adc_sample_t'(lfsr_take(14));
		fb_on = 1'b1;
		gain_sel_step = 5'd2;
		err_offset = 32'sd5000; // Constant error
		release_reset();
		exp_step = '0; // Integrator starts from reset
		for (int k = 0; k < 5; k++) begin
			wait_fir_strobe("closed_loop");
			filt = err_fir;
			exp_step = exp_step + (filt >>> gain_sel_step);
			tick();
			check_val("closed_loop", "o_step", exp_step, step);
		end
	endtask

	initial begin
		CLOCK_DAC = 1'b0;
		cycle_cnt = 0;
		lfsr_q = 32'd95575;
		reset_values();
		constant_adc();
		demod_levels();
		open_loop_ramp();
		closed_loop_step();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/fog_pkg.sv
src/fog_mod_gen.sv
src/fog_err_demod.sv
src/fog_fir.sv
src/fog_step_ctrl.sv
src/fog_phase_ramp.sv
src/fog_channel_top.sv
tests/fog_channel_props.sv
tests/tb_fog_channel.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: obj_dir/Vtb_fog_channel

obj_dir/Vtb_fog_channel: verilog.f $(SRCS) src/fog_macros.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_fog_channel -f verilog.f -o Vtb_fog_channel

run: obj_dir/Vtb_fog_channel
	./obj_dir/Vtb_fog_channel

clean:
	rm -rf obj_dir
